// File: common/tlb_settings.svh
`ifndef TLB_SETTINGS_SVH
`define TLB_SETTINGS_SVH

// table size.
`define TLB_ENTRY_NUM 16
`define TLB_IDX_WID   4

// random stimulus seed.
`define TLB_SEED 32'hec82

// cycle limit of a wait loop.
`define TLB_TIMEOUT 1000

`endif

// File: common/tlb_pkg.sv
`default_nettype none
`include "tlb_settings.svh"

package tlb_pkg;

    typedef logic [31:0]              vaddr_t;
    typedef logic [31:0]              paddr_t;
    typedef logic [18:0]              vppn_t;   // va[31:13].
    typedef logic [19:0]              ppn_t;
    typedef logic [9:0]               asid_t;
    typedef logic [5:0]               ps_t;     // log2 of page size.
    typedef logic [1:0]               plv_t;
    typedef logic [1:0]               mat_t;
    typedef logic [`TLB_IDX_WID-1:0]  tlb_idx_t;

    // one page of an even/odd pair.
    typedef struct packed {
        ppn_t ppn;
        plv_t plv;
        mat_t mat;
        logic d;
        logic v;
    } tlb_phy_t;

    typedef struct packed {
        logic           e;
        logic           g;
        vppn_t          vppn;
        ps_t            ps;
        asid_t          asid;
        tlb_phy_t [1:0] phy;    // indexed by the page half bit.
    } tlb_entry_t;

    typedef struct packed {
        logic v;
        logic d;
        plv_t plv;
        mat_t mat;
        logic g;
        ppn_t ppn;
    } tlbelo_t;

    typedef struct packed {
        logic     ne;
        ps_t      ps;
        tlb_idx_t index;
    } tlbidx_t;

    typedef struct packed {
        tlbidx_t       tlbidx;
        vppn_t         tlbehi;
        tlbelo_t [1:0] tlbelo;
        asid_t         asid;
    } tlb_csr_t;

    typedef struct packed {
        logic     we;
        tlb_csr_t csr;
    } tlb_csr_upd_t;

    typedef enum logic [2:0] {
        TLB_NOP,
        TLB_SRCH,
        TLB_RD,
        TLB_WR,
        TLB_FILL,
        TLB_INV
    } tlb_op_t;

    typedef struct packed {
        tlb_op_t    op;
        logic [4:0] inv_op;     // invtlb op code.
        asid_t      inv_asid;
        vppn_t      inv_vppn;
    } tlb_req_t;

    typedef enum logic [2:0] {
        CSR_TLBIDX,
        CSR_TLBEHI,
        CSR_TLBELO0,
        CSR_TLBELO1,
        CSR_ASID
    } csr_sel_t;

    typedef struct packed {
        logic     hit;
        tlb_idx_t idx;
        logic     v;
        logic     d;
        plv_t     plv;
        mat_t     mat;
        paddr_t   pa;
    } tlb_match_rsp_t;

endpackage

`default_nettype wire

// File: verilog/tlb_csr_regs.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_csr_regs
    import tlb_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  logic         csr_we,
    input  csr_sel_t     csr_sel,
    input  logic [31:0]  csr_wdata,
    input  tlb_csr_upd_t csr_upd,
    output tlb_csr_t     csr
);

    tlb_csr_t sw_csr;

    // tlbelo layout, v d plv mat g then ppn from bit 8.
    function automatic tlbelo_t unpack_elo(input logic [31:0] data);
        tlbelo_t elo;
        elo.v   = data[0];
        elo.d   = data[1];
        elo.plv = data[3:2];
        elo.mat = data[5:4];
        elo.g   = data[6];
        elo.ppn = data[8 +: $bits(ppn_t)];
        return elo;
    endfunction

    // image after a software write.
    always_comb begin
        sw_csr = csr;
        case (csr_sel)
            CSR_TLBIDX: begin
                sw_csr.tlbidx.index = csr_wdata[$bits(tlb_idx_t)-1:0];
                sw_csr.tlbidx.ps    = csr_wdata[29:24];
                sw_csr.tlbidx.ne    = csr_wdata[31];
            end
            CSR_TLBEHI: begin
                sw_csr.tlbehi = csr_wdata[31:13];
            end
            CSR_TLBELO0: begin
                sw_csr.tlbelo[0] = unpack_elo(csr_wdata);
            end
            CSR_TLBELO1: begin
                sw_csr.tlbelo[1] = unpack_elo(csr_wdata);
            end
            CSR_ASID: begin
                sw_csr.asid = csr_wdata[9:0];   // asidbits not stored.
            end
            default: ;
        endcase
    end

    // operation results beat software writes.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            csr <= '0;
        end else if (csr_upd.we) begin
            csr <= csr_upd.csr;
        end else if (csr_we) begin
            csr <= sw_csr;
        end
    end

endmodule

`default_nettype wire

// File: tlb/tlb_store.sv
`timescale 1ns/1ps
`default_nettype none
`include "tlb_settings.svh"

module tlb_store
    import tlb_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  tlb_req_t     tlb_req,
    input  tlb_csr_t     csr,
    input  logic         refill_mode,
    input  logic         srch_found,
    input  tlb_idx_t     srch_idx,
    output tlb_entry_t   entries [`TLB_ENTRY_NUM],
    output tlb_csr_upd_t csr_upd
);

    tlb_entry_t                entry_tab [`TLB_ENTRY_NUM];
    logic [`TLB_ENTRY_NUM-1:0] entry_e;
    logic [`TLB_ENTRY_NUM-1:0] inv_hit;
    tlb_idx_t                  fill_ptr;
    tlb_idx_t                  wr_idx;
    logic                      wr_en;
    tlb_entry_t                wr_entry;
    tlb_entry_t                rd_entry;

    assign wr_en  = (tlb_req.op == TLB_WR) || (tlb_req.op == TLB_FILL);
    assign wr_idx = (tlb_req.op == TLB_FILL) ? fill_ptr : csr.tlbidx.index;

    // entry image built from the csrs.
    always_comb begin
        wr_entry.e    = refill_mode | ~csr.tlbidx.ne;
        wr_entry.g    = csr.tlbelo[0].g & csr.tlbelo[1].g;
        wr_entry.vppn = csr.tlbehi;
        wr_entry.ps   = csr.tlbidx.ps;
        wr_entry.asid = csr.asid;
        for (int k = 0; k < 2; k++) begin
            wr_entry.phy[k].ppn = csr.tlbelo[k].ppn;
            wr_entry.phy[k].plv = csr.tlbelo[k].plv;
            wr_entry.phy[k].mat = csr.tlbelo[k].mat;
            wr_entry.phy[k].d   = csr.tlbelo[k].d;
            wr_entry.phy[k].v   = csr.tlbelo[k].v;
        end
    end

    // victim pointer for tlbfill.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fill_ptr <= '0;
        end else if (tlb_req.op == TLB_FILL) begin
            if (fill_ptr == tlb_idx_t'(`TLB_ENTRY_NUM - 1)) begin
                fill_ptr <= '0;
            end else begin
                fill_ptr <= fill_ptr + 1'b1;
            end
        end
    end

    always_comb begin
        for (int j = 0; j < `TLB_ENTRY_NUM; j++) begin
            case (tlb_req.inv_op)
                5'd0, 5'd1: inv_hit[j] = 1'b1;
                5'd2:       inv_hit[j] = entry_tab[j].g;
                5'd3:       inv_hit[j] = ~entry_tab[j].g;
                5'd4:       inv_hit[j] = ~entry_tab[j].g && entry_tab[j].asid == tlb_req.inv_asid;
                5'd5:       inv_hit[j] = ~entry_tab[j].g && entry_tab[j].asid == tlb_req.inv_asid
                                         && entry_tab[j].vppn == tlb_req.inv_vppn;
                5'd6:       inv_hit[j] = (entry_tab[j].g || entry_tab[j].asid == tlb_req.inv_asid)
                                         && entry_tab[j].vppn == tlb_req.inv_vppn;
                default:    inv_hit[j] = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            entry_tab[wr_idx] <= wr_entry;
        end
    end

    // valid bits live apart from the payload.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            entry_e <= '0;
        end else if (wr_en) begin
            entry_e[wr_idx] <= wr_entry.e;
        end else if (tlb_req.op == TLB_INV) begin
            entry_e <= entry_e & ~inv_hit;
        end
    end

    always_comb begin
        for (int j = 0; j < `TLB_ENTRY_NUM; j++) begin
            entries[j]   = entry_tab[j];
            entries[j].e = entry_e[j];
        end
    end

    assign rd_entry = entries[csr.tlbidx.index];

    // result of tlbsrch and tlbrd.
    always_comb begin
        csr_upd.we  = 1'b0;
        csr_upd.csr = csr;
        case (tlb_req.op)
            TLB_SRCH: begin
                csr_upd.we            = 1'b1;
                csr_upd.csr.tlbidx.ne = ~srch_found;
                if (srch_found) begin
                    csr_upd.csr.tlbidx.index = srch_idx;
                end
            end
            TLB_RD: begin
                csr_upd.we = 1'b1;
                if (rd_entry.e) begin
                    csr_upd.csr.tlbidx.ne = 1'b0;
                    csr_upd.csr.tlbidx.ps = rd_entry.ps;
                    csr_upd.csr.tlbehi    = rd_entry.vppn;
                    csr_upd.csr.asid      = rd_entry.asid;
                    for (int k = 0; k < 2; k++) begin
                        csr_upd.csr.tlbelo[k].ppn = rd_entry.phy[k].ppn;
                        csr_upd.csr.tlbelo[k].plv = rd_entry.phy[k].plv;
                        csr_upd.csr.tlbelo[k].mat = rd_entry.phy[k].mat;
                        csr_upd.csr.tlbelo[k].d   = rd_entry.phy[k].d;
                        csr_upd.csr.tlbelo[k].v   = rd_entry.phy[k].v;
                        csr_upd.csr.tlbelo[k].g   = rd_entry.g;
                    end
                end else begin
                    csr_upd.csr.tlbidx.ne = 1'b1;   // index is kept.
                    csr_upd.csr.tlbidx.ps = '0;
                    csr_upd.csr.tlbehi    = '0;
                    csr_upd.csr.tlbelo    = '0;
                    csr_upd.csr.asid      = '0;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: tlb/tlb_match.sv
`timescale 1ns/1ps
`default_nettype none
`include "tlb_settings.svh"

module tlb_match
    import tlb_pkg::*;
(
    input  tlb_entry_t     entries [`TLB_ENTRY_NUM],
    input  vaddr_t         va,
    input  asid_t          asid,
    output tlb_match_rsp_t rsp
);

    localparam ps_t PS_2M = 6'd21;

    logic [`TLB_ENTRY_NUM-1:0] hit_vec;
    logic                      hit;
    tlb_idx_t                  hit_idx;
    tlb_entry_t                sel;
    logic                      half;
    tlb_phy_t                  phy;

    always_comb begin
        for (int j = 0; j < `TLB_ENTRY_NUM; j++) begin
            if (entries[j].ps == PS_2M) begin
                hit_vec[j] = entries[j].vppn[18:9] == va[31:22];   // huge page.
            end else begin
                hit_vec[j] = entries[j].vppn == va[31:13];
            end
            hit_vec[j] = hit_vec[j] & entries[j].e
                         & (entries[j].g | (entries[j].asid == asid));
        end
    end

    // lowest index wins.
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int j = `TLB_ENTRY_NUM - 1; j >= 0; j--) begin
            if (hit_vec[j]) begin
                hit     = 1'b1;
                hit_idx = tlb_idx_t'(j);
            end
        end
    end

    assign sel  = entries[hit_idx];
    assign half = (sel.ps == PS_2M) ? va[21] : va[12];
    assign phy  = sel.phy[half];

    always_comb begin
        rsp     = '0;
        rsp.hit = hit;
        rsp.idx = hit_idx;
        if (hit) begin
            rsp.v   = phy.v;
            rsp.d   = phy.d;
            rsp.plv = phy.plv;
            rsp.mat = phy.mat;
            if (sel.ps == PS_2M) begin
                rsp.pa = {phy.ppn[19:9], va[20:0]};
            end else begin
                rsp.pa = {phy.ppn, va[11:0]};
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/tlb_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "tlb_settings.svh"

module tlb_unit
    import tlb_pkg::*;
(
    input  logic           clk,
    input  logic           arst_n,
    input  logic           csr_we,
    input  csr_sel_t       csr_sel,
    input  logic [31:0]    csr_wdata,
    input  tlb_req_t       tlb_req,
    input  logic           refill_mode,
    input  vaddr_t         lookup_va,
    input  asid_t          lookup_asid,
    output tlb_csr_t       csr,
    output tlb_match_rsp_t lookup_rsp
);

    tlb_entry_t     entries [`TLB_ENTRY_NUM];
    tlb_csr_upd_t   csr_upd;
    tlb_match_rsp_t srch_rsp;

    tlb_csr_regs tlb_csr_regs_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .csr_we    (csr_we),
        .csr_sel   (csr_sel),
        .csr_wdata (csr_wdata),
        .csr_upd   (csr_upd),
        .csr       (csr)
    );

    tlb_store tlb_store_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .tlb_req     (tlb_req),
        .csr         (csr),
        .refill_mode (refill_mode),
        .srch_found  (srch_rsp.hit),
        .srch_idx    (srch_rsp.idx),
        .entries     (entries),
        .csr_upd     (csr_upd)
    );

    // tlbsrch key, only hit and idx are used.
    tlb_match tlb_search_i (
        .entries (entries),
        .va      ({csr.tlbehi, {13{1'b0}}}),
        .asid    (csr.asid),
        .rsp     (srch_rsp)
    );

    tlb_match tlb_lookup_i (
        .entries (entries),
        .va      (lookup_va),
        .asid    (lookup_asid),
        .rsp     (lookup_rsp)
    );

endmodule

`default_nettype wire

// File: sim/tlb_props.sv
`timescale 1ns/1ps
`default_nettype none
`include "tlb_settings.svh"

module tlb_props
    import tlb_pkg::*;
(
    input logic           clk,
    input logic           arst_n,
    input tlb_req_t       tlb_req,
    input tlb_csr_t       csr,
    input tlb_csr_upd_t   csr_upd,
    input tlb_match_rsp_t lookup_rsp,
    input tlb_entry_t     entries [`TLB_ENTRY_NUM]
);

    // only srch and rd write back.
    upd_needs_op: assert property (@(posedge clk) disable iff (!arst_n)
        csr_upd.we |-> (tlb_req.op == TLB_SRCH || tlb_req.op == TLB_RD))
        else $error("CSR update without a search or read request");

    hit_entry_valid: assert property (@(posedge clk) disable iff (!arst_n)
        lookup_rsp.hit |-> entries[lookup_rsp.idx].e)
        else $error("lookup hit on an entry that is not valid");

    no_unknown: assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown({csr, csr_upd, lookup_rsp, tlb_req}))
        else $error("unknown value on a CSR, update, lookup or request");

endmodule

`default_nettype wire

// File: sim/tlb_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "tlb_settings.svh"

module tlb_tb
    import tlb_pkg::*;
();

    logic           clk;
    logic           arst_n;
    logic           csr_we;
    csr_sel_t       csr_sel;
    logic [31:0]    csr_wdata;
    tlb_req_t       tlb_req;
    logic           refill_mode;
    vaddr_t         lookup_va;
    asid_t          lookup_asid;
    tlb_csr_t       csr;
    tlb_match_rsp_t lookup_rsp;

    tlb_csr_t    m_csr;     // model state.
    tlb_entry_t  m_ent [`TLB_ENTRY_NUM];
    int          m_ptr;
    logic [31:0] rng;

    tlb_unit tlb_unit_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .csr_we      (csr_we),
        .csr_sel     (csr_sel),
        .csr_wdata   (csr_wdata),
        .tlb_req     (tlb_req),
        .refill_mode (refill_mode),
        .lookup_va   (lookup_va),
        .lookup_asid (lookup_asid),
        .csr         (csr),
        .lookup_rsp  (lookup_rsp)
    );

    bind tlb_unit tlb_props tlb_props_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .tlb_req    (tlb_req),
        .csr        (csr),
        .csr_upd    (csr_upd),
        .lookup_rsp (lookup_rsp),
        .entries    (entries)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // small pools so that pages and asids collide.
    function automatic vppn_t pick_vppn(input logic [31:0] r);
        return {(r[0] ? 10'h2a5 : 10'h0c3), r[3], 6'd0, r[2:1]};
    endfunction

    function automatic asid_t pick_asid(input logic [31:0] r);
        return r[5] ? 10'h3ff : {9'd0, r[4]};
    endfunction

    function automatic logic entry_hits(input tlb_entry_t en, input vaddr_t va, input asid_t asid);
        logic page_eq;
        page_eq = (en.ps == 6'd21) ? (en.vppn[18:9] == va[31:22]) : (en.vppn == va[31:13]);
        return en.e && (en.g || en.asid == asid) && page_eq;
    endfunction

    function automatic tlb_match_rsp_t model_lookup(input vaddr_t va, input asid_t asid);
        tlb_match_rsp_t rsp;
        tlb_phy_t       p;
        logic           big;
        logic [31:0]    mask;
        rsp = '0;
        for (int j = 0; j < `TLB_ENTRY_NUM; j++) begin
            if (!rsp.hit && entry_hits(m_ent[j], va, asid)) begin
                big  = m_ent[j].ps == 6'd21;
                p    = m_ent[j].phy[big ? va[21] : va[12]];
                mask = big ? 32'h001f_ffff : 32'h0000_0fff;
                rsp  = '{hit: 1'b1, idx: tlb_idx_t'(j), v: p.v, d: p.d, plv: p.plv,
                         mat: p.mat, pa: ({p.ppn, 12'd0} & ~mask) | (va & mask)};
            end
        end
        return rsp;
    endfunction

    function automatic logic inv_match(input tlb_entry_t en, input tlb_req_t req);
        logic same_asid;
        logic same_page;
        same_asid = en.asid == req.inv_asid;
        same_page = en.vppn == req.inv_vppn;
        case (req.inv_op)
            5'd0, 5'd1: return 1'b1;
            5'd2:       return en.g;
            5'd3:       return !en.g;
            5'd4:       return !en.g && same_asid;
            5'd5:       return !en.g && same_asid && same_page;
            5'd6:       return (en.g || same_asid) && same_page;
            default:    return 1'b0;
        endcase
    endfunction

    task automatic update_model(input tlb_req_t req, input logic refill);
        tlb_entry_t en;
        tlb_idx_t   idx;
        logic       found;
        case (req.op)
            TLB_WR, TLB_FILL: begin
                idx     = (req.op == TLB_FILL) ? tlb_idx_t'(m_ptr) : m_csr.tlbidx.index;
                en.e    = refill || !m_csr.tlbidx.ne;
                en.g    = m_csr.tlbelo[0].g && m_csr.tlbelo[1].g;
                en.vppn = m_csr.tlbehi;
                en.ps   = m_csr.tlbidx.ps;
                en.asid = m_csr.asid;
                for (int k = 0; k < 2; k++) begin
                    en.phy[k] = '{ppn: m_csr.tlbelo[k].ppn, plv: m_csr.tlbelo[k].plv,
                                  mat: m_csr.tlbelo[k].mat, d: m_csr.tlbelo[k].d,
                                  v: m_csr.tlbelo[k].v};
                end
                m_ent[idx] = en;
                if (req.op == TLB_FILL) begin
                    m_ptr = (m_ptr + 1) % `TLB_ENTRY_NUM;
                end
            end
            TLB_SRCH: begin
                found = 1'b0;
                for (int j = 0; j < `TLB_ENTRY_NUM; j++) begin
                    if (!found && entry_hits(m_ent[j], {m_csr.tlbehi, 13'd0}, m_csr.asid)) begin
                        found              = 1'b1;
                        m_csr.tlbidx.index = tlb_idx_t'(j);
                    end
                end
                m_csr.tlbidx.ne = !found;
            end
            TLB_RD: begin
                idx = m_csr.tlbidx.index;
                en  = m_ent[idx];
                if (en.e) begin
                    m_csr.tlbidx.ne = 1'b0;
                    m_csr.tlbidx.ps = en.ps;
                    m_csr.tlbehi    = en.vppn;
                    m_csr.asid      = en.asid;
                    for (int k = 0; k < 2; k++) begin
                        m_csr.tlbelo[k] = '{v: en.phy[k].v, d: en.phy[k].d, plv: en.phy[k].plv,
                                            mat: en.phy[k].mat, g: en.g, ppn: en.phy[k].ppn};
                    end
                end else begin
                    m_csr              = '0;
                    m_csr.tlbidx.ne    = 1'b1;
                    m_csr.tlbidx.index = idx;
                end
            end
            TLB_INV: begin
                for (int j = 0; j < `TLB_ENTRY_NUM; j++) begin
                    if (inv_match(m_ent[j], req)) begin
                        m_ent[j].e = 1'b0;
                    end
                end
            end
            default: ;
        endcase
    endtask

    task automatic fail_run();
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic report_mismatch(input string what, input logic [127:0] got,
                                   input logic [127:0] exp);
        $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        fail_run();
    endtask

    task automatic check_outputs();
        tlb_match_rsp_t exp_rsp;
        exp_rsp = model_lookup(lookup_va, lookup_asid);
        assert (csr === m_csr)
            else report_mismatch("CSR image", 128'(csr), 128'(m_csr));
        assert (lookup_rsp === exp_rsp)
            else report_mismatch("lookup response", 128'(lookup_rsp), 128'(exp_rsp));
    endtask

    // mode 0 lookups only, 1 writes and reads, 2 everything.
    task automatic step(input int mode);
        logic [31:0] r;
        logic [31:0] s;
        int          kind;
        ps_t         ps;
        @(negedge clk);
        check_outputs();
        r           = next_rand();
        s           = next_rand();
        kind        = (mode == 0) ? 8 : (mode == 1) ? int'(r[2:0]) % 6 : int'(r[2:0]);
        csr_we      = 1'b0;
        tlb_req     = '0;
        refill_mode = r[31] & r[30];
        lookup_va   = {pick_vppn(s), s[20:8]};
        lookup_asid = pick_asid(s);
        case (kind)
            0, 1, 2: begin
                csr_we  = 1'b1;
                csr_sel = csr_sel_t'(r[6:4] % 3'd5);
                case (csr_sel)
                    CSR_TLBIDX: begin
                        ps           = s[0] ? 6'd21 : 6'd12;
                        csr_wdata    = {s[1] & s[2], 1'b0, ps, 20'd0, s[7:4]};
                        m_csr.tlbidx = '{ne: s[1] & s[2], ps: ps, index: s[7:4]};
                    end
                    CSR_TLBEHI: begin
                        csr_wdata    = {pick_vppn(s), s[20:8]};
                        m_csr.tlbehi = pick_vppn(s);
                    end
                    CSR_TLBELO0, CSR_TLBELO1: begin
                        csr_wdata = {4'd0, s[27:8], 1'b0, s[6:0]};
                        m_csr.tlbelo[csr_sel == CSR_TLBELO1] = '{v: s[0], d: s[1], plv: s[3:2],
                                                                  mat: s[5:4], g: s[6],
                                                                  ppn: s[27:8]};
                    end
                    default: begin
                        csr_wdata  = {s[31:10], pick_asid(s)};
                        m_csr.asid = pick_asid(s);
                    end
                endcase
            end
            3: tlb_req.op = TLB_WR;
            4: tlb_req.op = TLB_FILL;
            5: tlb_req.op = TLB_RD;
            6: tlb_req.op = TLB_SRCH;
            7: begin
                tlb_req.op       = TLB_INV;
                tlb_req.inv_op   = {2'd0, s[23:21]};
                tlb_req.inv_asid = pick_asid(r);
                tlb_req.inv_vppn = pick_vppn(r >> 8);
            end
            default: ;
        endcase
        update_model(tlb_req, refill_mode);
    endtask

    initial begin
        int cnt;
        rng         = `TLB_SEED;
        arst_n      = 1'b0;
        csr_we      = 1'b0;
        csr_sel     = CSR_TLBIDX;
        csr_wdata   = '0;
        tlb_req     = '0;
        refill_mode = 1'b0;
        lookup_va   = '0;
        lookup_asid = '0;
        m_csr       = '0;
        m_ptr       = 0;
        for (int j = 0; j < `TLB_ENTRY_NUM; j++) begin
            m_ent[j] = '0;
        end
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        cnt    = 0;
        while (csr !== '0) begin
            @(negedge clk);
            cnt++;
            if (cnt >= `TLB_TIMEOUT) begin
                $display("Timeout: the CSRs did not clear after reset");
                fail_run();
            end
        end
        repeat (40) step(0);
        repeat (400) step(1);
        repeat (3000) step(2);
        @(negedge clk);
        check_outputs();
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+common
common/tlb_pkg.sv
verilog/tlb_csr_regs.sv
tlb/tlb_store.sv
tlb/tlb_match.sv
verilog/tlb_unit.sv
sim/tlb_props.sv
sim/tlb_tb.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := tlb_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) common/tlb_settings.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
